/* dcache_top.f */
hdl/dcache_pkg.sv
hdl/victim_select.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/dcache_fsm.sv
hdl/dcache_top.sv
tests/clk_gen.sv
tests/bus_mem_model.sv
tests/tb_dcache_top.sv

/* hdl/data_store.sv */
`timescale 1ns/100ps

module data_store
    import dcache_pkg::*;
(
    input  logic               clk_i,
    input  cache_addr_u        addr_i,
    input  logic [WAY_W-1:0]   way_i,
    input  logic               fill_we_i,
    input  logic [BLOCK_W-1:0] fill_block_i,
    input  logic               word_we_i,
    input  logic [DATA_W-1:0]  wr_word_i,

    output logic [DATA_W-1:0]  rd_word_o,
    output logic [BLOCK_W-1:0] sel_block_o
);

    logic [BLOCK_W-1:0] block_mem [0:SETS-1][0:WAYS-1];

    logic [$clog2(WORDS_PER_BLOCK)-1:0] word_idx;

    // Word index is the upper part of the byte offset
    assign word_idx = addr_i.f.offset[OFFSET_W-1 -: $clog2(WORDS_PER_BLOCK)];

    assign sel_block_o = block_mem[addr_i.f.set][way_i];
    assign rd_word_o   = sel_block_o[word_idx * DATA_W +: DATA_W];

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            block_mem[addr_i.f.set][way_i] <= fill_block_i;
        end else if (word_we_i) begin
            block_mem[addr_i.f.set][way_i][word_idx * DATA_W +: DATA_W] <= wr_word_i;
        end
    end

endmodule

/* hdl/dcache_fsm.sv */
`timescale 1ns/100ps

module dcache_fsm
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,

    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              req_ready_o,

    output logic [DATA_W-1:0] rsp_data_o,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,

    output logic [ADDR_W-1:0] bus_addr_o,
    output logic              bus_valid_o,
    input  logic              bus_ready_i,
    output logic              bus_write_o,
    input  logic              bus_rvalid_i,
    output logic              bus_rready_o,

    input  logic              hit_i,
    input  logic [WAY_W-1:0]  hit_way_i,
    input  logic [WAY_W-1:0]  victim_way_i,
    input  logic              victim_dirty_i,
    input  logic              victim_valid_i,
    input  logic [TAG_W-1:0]  victim_tag_i,
    input  logic [DATA_W-1:0] rd_word_i,

    output cache_addr_u       req_addr_o,
    output logic [WAY_W-1:0]  fill_way_o,
    output logic              tag_we_o,
    output logic              fill_we_o,
    output logic              word_we_o,
    output logic [DATA_W-1:0] wr_word_o,
    output logic              victim_adv_o
);

    logic [STATE_W-1:0] state_r;
    logic [STATE_W-1:0] state_ns;

    cache_addr_u        addr_r;
    logic               write_r;
    logic [DATA_W-1:0]  wdata_r;
    logic [DATA_W-1:0]  rsp_data_r;
    logic [WAY_W-1:0]   fill_way_r;
    cache_addr_u        bus_addr;

    logic               accept;
    logic               lookup_miss;

    assign accept      = req_valid_i && req_ready_o;
    assign lookup_miss = (state_r == ST_LOOKUP) && !hit_i;

    assign req_ready_o  = (state_r == ST_IDLE);
    assign rsp_valid_o  = (state_r == ST_RESPOND);
    assign rsp_data_o   = rsp_data_r;
    assign bus_valid_o  = (state_r == ST_WB_REQ) || (state_r == ST_FILL_REQ);
    assign bus_write_o  = (state_r == ST_WB_REQ);
    assign bus_rready_o = (state_r == ST_FILL_WAIT);

    assign req_addr_o = addr_r;
    assign wr_word_o  = wdata_r;

    // Lookup works on the hit way, every other access on the frozen victim
    assign fill_way_o = (state_r == ST_LOOKUP) ? hit_way_i : fill_way_r;

    // Write-back goes to the victim's own block, refill to the requested one
    always_comb begin
        bus_addr.f.tag    = (state_r == ST_WB_REQ) ? victim_tag_i : addr_r.f.tag;
        bus_addr.f.set    = addr_r.f.set;
        bus_addr.f.offset = '0;
        bus_addr_o        = bus_addr.raw;
    end

    always_comb begin
        state_ns     = state_r;
        tag_we_o     = 1'b0;
        fill_we_o    = 1'b0;
        word_we_o    = 1'b0;
        victim_adv_o = 1'b0;

        case (state_r)
            ST_IDLE: begin
                if (accept) begin
                    state_ns = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit_i && write_r) begin
                    word_we_o = 1'b1;
                    state_ns  = ST_IDLE;
                end else if (hit_i) begin
                    state_ns = ST_RESPOND;
                end else begin
                    // Pointer moves only when a valid block is displaced
                    victim_adv_o = victim_valid_i;
                    if (victim_valid_i && victim_dirty_i) begin
                        state_ns = ST_WB_REQ;
                    end else begin
                        state_ns = ST_FILL_REQ;
                    end
                end
            end
            ST_RESPOND: begin
                if (rsp_ready_i) begin
                    state_ns = ST_IDLE;
                end
            end
            ST_WB_REQ: begin
                if (bus_ready_i) begin
                    state_ns = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ: begin
                if (bus_ready_i) begin
                    state_ns = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                if (bus_rvalid_i) begin
                    tag_we_o  = 1'b1;
                    fill_we_o = 1'b1;
                    state_ns  = ST_LOOKUP;
                end
            end
            default: begin
                state_ns = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r <= ST_IDLE;
        end else begin
            state_r <= state_ns;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_r.raw <= req_addr_i;
            write_r    <= req_write_i;
            wdata_r    <= req_wdata_i;
        end
        if ((state_r == ST_LOOKUP) && hit_i && !write_r) begin
            rsp_data_r <= rd_word_i;
        end
        if (lookup_miss) begin
            fill_way_r <= victim_way_i;
        end
    end

endmodule

/* hdl/dcache_pkg.sv */
package dcache_pkg;

    // Address and data sizes
    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;
    localparam int BLOCK_W         = 128;
    localparam int WORDS_PER_BLOCK = BLOCK_W / DATA_W;

    // Address split
    localparam int OFFSET_W = 4;
    localparam int SET_W    = 4;
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;

    // Organization
    localparam int SETS  = 16;
    localparam int WAYS  = 4;
    localparam int WAY_W = 2;

    // Controller states
    localparam int STATE_W = 3;

    localparam logic [STATE_W-1:0] ST_IDLE      = 3'd0;
    localparam logic [STATE_W-1:0] ST_LOOKUP    = 3'd1;
    localparam logic [STATE_W-1:0] ST_RESPOND   = 3'd2;
    localparam logic [STATE_W-1:0] ST_WB_REQ    = 3'd3;
    localparam logic [STATE_W-1:0] ST_FILL_REQ  = 3'd4;
    localparam logic [STATE_W-1:0] ST_FILL_WAIT = 3'd5;

    // Byte address seen either as one word or as its cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [SET_W-1:0]    set;
            logic [OFFSET_W-1:0] offset;
        } f;
    } cache_addr_u;

endpackage

/* hdl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic               req_valid_i,
    input  logic               req_write_i,
    input  logic [DATA_W-1:0]  req_wdata_i,
    output logic               req_ready_o,

    output logic [DATA_W-1:0]  rsp_data_o,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,

    output logic [ADDR_W-1:0]  bus_addr_o,
    output logic               bus_valid_o,
    input  logic               bus_ready_i,
    output logic               bus_write_o,
    output logic [BLOCK_W-1:0] bus_wdata_o,
    input  logic [BLOCK_W-1:0] bus_rdata_i,
    input  logic               bus_rvalid_i,
    output logic               bus_rready_o
);

    cache_addr_u       req_addr;
    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic [WAYS-1:0]   valid_mask;
    logic [WAYS-1:0]   dirty_mask;
    logic [TAG_W-1:0]  sel_tag;
    logic [WAY_W-1:0]  victim_way;
    logic [WAY_W-1:0]  fill_way;
    logic              tag_we;
    logic              fill_we;
    logic              word_we;
    logic [DATA_W-1:0] wr_word;
    logic [DATA_W-1:0] rd_word;
    logic              victim_adv;

    dcache_fsm u_dcache_fsm (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_addr_i     (req_addr_i),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_wdata_i    (req_wdata_i),
        .req_ready_o    (req_ready_o),
        .rsp_data_o     (rsp_data_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .bus_addr_o     (bus_addr_o),
        .bus_valid_o    (bus_valid_o),
        .bus_ready_i    (bus_ready_i),
        .bus_write_o    (bus_write_o),
        .bus_rvalid_i   (bus_rvalid_i),
        .bus_rready_o   (bus_rready_o),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (dirty_mask[victim_way]),
        .victim_valid_i (valid_mask[victim_way]),
        .victim_tag_i   (sel_tag),
        .rd_word_i      (rd_word),
        .req_addr_o     (req_addr),
        .fill_way_o     (fill_way),
        .tag_we_o       (tag_we),
        .fill_we_o      (fill_we),
        .word_we_o      (word_we),
        .wr_word_o      (wr_word),
        .victim_adv_o   (victim_adv)
    );

    tag_store u_tag_store (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .addr_i       (req_addr),
        .way_i        (fill_way),
        .tag_we_i     (tag_we),
        .dirty_set_i  (word_we),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .valid_mask_o (valid_mask),
        .dirty_mask_o (dirty_mask),
        .sel_tag_o    (sel_tag)
    );

    data_store u_data_store (
        .clk_i        (clk_i),
        .addr_i       (req_addr),
        .way_i        (fill_way),
        .fill_we_i    (fill_we),
        .fill_block_i (bus_rdata_i),
        .word_we_i    (word_we),
        .wr_word_i    (wr_word),
        .rd_word_o    (rd_word),
        .sel_block_o  (bus_wdata_o)
    );

    victim_select u_victim_select (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_mask_i (valid_mask),
        .adv_i        (victim_adv),
        .victim_way_o (victim_way)
    );

endmodule

/* hdl/tag_store.sv */
`timescale 1ns/100ps

module tag_store
    import dcache_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  cache_addr_u      addr_i,
    input  logic [WAY_W-1:0] way_i,
    input  logic             tag_we_i,
    input  logic             dirty_set_i,

    output logic             hit_o,
    output logic [WAY_W-1:0] hit_way_o,
    output logic [WAYS-1:0]  valid_mask_o,
    output logic [WAYS-1:0]  dirty_mask_o,
    output logic [TAG_W-1:0] sel_tag_o
);

    logic [TAG_W-1:0] tag_mem [0:SETS-1][0:WAYS-1];
    logic [WAYS-1:0]  valid_r [0:SETS-1];
    logic [WAYS-1:0]  dirty_r [0:SETS-1];

    assign valid_mask_o = valid_r[addr_i.f.set];
    assign dirty_mask_o = dirty_r[addr_i.f.set];
    assign sel_tag_o    = tag_mem[addr_i.f.set][way_i];

    // At most one valid way of a set can hold a given tag
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (valid_mask_o[i] && (tag_mem[addr_i.f.set][i] == addr_i.f.tag)) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (tag_we_i) begin
            tag_mem[addr_i.f.set][way_i] <= addr_i.f.tag;
        end
    end

    // A refill leaves the block clean, a word write marks it dirty
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
            end
        end else if (tag_we_i) begin
            valid_r[addr_i.f.set][way_i] <= 1'b1;
            dirty_r[addr_i.f.set][way_i] <= 1'b0;
        end else if (dirty_set_i) begin
            dirty_r[addr_i.f.set][way_i] <= 1'b1;
        end
    end

endmodule

/* hdl/victim_select.sv */
`timescale 1ns/100ps

module victim_select
    import dcache_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic [WAYS-1:0]  valid_mask_i,
    input  logic             adv_i,
    output logic [WAY_W-1:0] victim_way_o
);

    logic [WAY_W-1:0] ptr_r;
    logic             any_invalid;

    assign any_invalid = ~&valid_mask_i;

    // Lowest invalid way first, round-robin pointer once the set is full
    always_comb begin
        victim_way_o = ptr_r;
        if (any_invalid) begin
            for (int i = WAYS - 1; i >= 0; i--) begin
                if (!valid_mask_i[i]) begin
                    victim_way_o = WAY_W'(i);
                end
            end
        end
    end

    // One pointer shared by every set
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ptr_r <= '0;
        end else if (adv_i) begin
            if (ptr_r == WAY_W'(WAYS - 1)) begin
                ptr_r <= '0;
            end else begin
                ptr_r <= ptr_r + 1'b1;
            end
        end
    end

endmodule

/* tests/bus_mem_model.sv */
`timescale 1ns/100ps

module bus_mem_model #(
    parameter int MEM_WORDS = 4096
) (
    input  logic         clk_i,
    input  logic [31:0]  bus_addr_i,
    input  logic         bus_valid_i,
    output logic         bus_ready_o,
    input  logic         bus_write_i,
    input  logic [127:0] bus_wdata_i,
    output logic [127:0] bus_rdata_o,
    output logic         bus_rvalid_o,
    input  logic         bus_rready_i
);

    // Filled by the testbench before the first request
    logic [31:0] mem_words [0:MEM_WORDS-1];

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin : serve
        int unsigned  base;
        bit           write;
        logic [127:0] block;
        bus_ready_o  = 1'b0;
        bus_rvalid_o = 1'b0;
        bus_rdata_o  = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (bus_valid_i) begin
                idle_cycles($urandom_range(0, 3));
                base        = (bus_addr_i >> 2) % MEM_WORDS;
                write       = bus_write_i;
                block       = bus_wdata_i;
                bus_ready_o = 1'b1;
                @(posedge clk_i);
                #1;
                bus_ready_o = 1'b0;
                if (write) begin
                    for (int i = 0; i < 4; i++) begin
                        mem_words[base + i] = block[i*32 +: 32];
                    end
                end else begin
                    idle_cycles($urandom_range(0, 3));
                    for (int i = 0; i < 4; i++) begin
                        bus_rdata_o[i*32 +: 32] = mem_words[base + i];
                    end
                    bus_rvalid_o = 1'b1;
                    while (!bus_rready_i) begin
                        @(posedge clk_i);
                        #1;
                    end
                    @(posedge clk_i);
                    #1;
                    bus_rvalid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 8;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;
    end

endmodule

/* tests/tb_dcache_top.sv */
`timescale 1ns/100ps

module tb_dcache_top;

    localparam logic [31:0] SEED        = 32'h0096bd39;
    localparam int          N_RAND      = 200;
    localparam int          N_OPS       = N_RAND + 12;
    localparam int          MEM_WORDS   = 4096;
    localparam int          WATCHDOG_NS = N_OPS * 40 * 8 + 200;

    logic         clk;
    logic         rstn;
    logic [31:0]  req_addr;
    logic         req_valid;
    logic         req_write;
    logic [31:0]  req_wdata;
    logic         req_ready;
    logic [31:0]  rsp_data;
    logic         rsp_valid;
    logic         rsp_ready;
    logic [31:0]  bus_addr;
    logic         bus_valid;
    logic         bus_ready;
    logic         bus_write;
    logic [127:0] bus_wdata;
    logic [127:0] bus_rdata;
    logic         bus_rvalid;
    logic         bus_rready;

    int           errors;
    logic [31:0]  sb_mem  [0:MEM_WORDS-1];
    logic [23:0]  m_tag   [16][4];
    bit           m_valid [16][4];
    bit           m_dirty [16][4];
    int unsigned  m_ptr;

    // Bus transfers seen during the current access
    logic [31:0]  q_addr  [$];
    bit           q_write [$];
    logic [127:0] q_data  [$];

    clk_gen u_clk_gen (.clk_o(clk), .rstn_o(rstn));

    bus_mem_model #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk_i(clk), .bus_addr_i(bus_addr), .bus_valid_i(bus_valid), .bus_ready_o(bus_ready),
        .bus_write_i(bus_write), .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata),
        .bus_rvalid_o(bus_rvalid), .bus_rready_i(bus_rready)
    );

    dcache_top u_dcache_top (
        .clk_i(clk), .rstn_i(rstn),
        .req_addr_i(req_addr), .req_valid_i(req_valid), .req_write_i(req_write),
        .req_wdata_i(req_wdata), .req_ready_o(req_ready),
        .rsp_data_o(rsp_data), .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready),
        .bus_addr_o(bus_addr), .bus_valid_o(bus_valid), .bus_ready_i(bus_ready),
        .bus_write_o(bus_write), .bus_wdata_o(bus_wdata), .bus_rdata_i(bus_rdata),
        .bus_rvalid_i(bus_rvalid), .bus_rready_o(bus_rready)
    );

    function automatic logic [31:0] mem_pattern(input int unsigned idx);
        return (idx * 32'd4) * 32'h9e3779b1 ^ 32'h2c1b3a5f;
    endfunction

    function automatic logic [127:0] block_of(input logic [31:0] addr);
        int unsigned b;
        b = {addr[13:4], 2'b00};
        return {sb_mem[b + 3], sb_mem[b + 2], sb_mem[b + 1], sb_mem[b]};
    endfunction

    function automatic bit pick_ready(input bit rnd);
        return rnd ? ($urandom_range(0, 3) != 0) : 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // Monitor at the falling edge where valid and ready are settled
    always @(negedge clk) begin
        if (bus_valid && bus_ready) begin
            q_addr.push_back(bus_addr);
            q_write.push_back(bus_write);
            q_data.push_back(bus_wdata);
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
        errors++;
        $display("Response dropped or changed before rsp_ready_i was high");
    end

    assert property (@(posedge clk) disable iff (!rstn) rsp_valid |-> !req_ready)
    else begin
        errors++;
        $display("Cache was ready for a request while a response was pending");
    end

    assert property (@(posedge clk) disable iff (!rstn)
        bus_valid && !bus_ready |=> bus_valid && $stable(bus_addr) && $stable(bus_write))
    else begin
        errors++;
        $display("Bus request dropped or changed before bus_ready_i was high");
    end

    assert property (@(posedge clk) disable iff (!rstn) bus_valid |-> bus_addr[3:0] == 4'h0)
    else begin
        errors++;
        $display("Bus address is not block aligned");
    end

    task automatic run_access(input bit wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input bit rnd);
        int unsigned  s_idx;
        int unsigned  way;
        int unsigned  idx;
        int unsigned  edges;
        int unsigned  n_exp;
        bit           hit;
        logic [31:0]  got;
        logic [31:0]  exp_addr [2];
        bit           exp_wr   [2];
        logic [127:0] exp_data [2];
        s_idx = addr[7:4];
        idx   = addr[13:2];
        hit   = 1'b0;
        n_exp = 0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[s_idx][w] && m_tag[s_idx][w] == addr[31:8]) begin
                hit = 1'b1;
                way = w;
            end
        end
        // A miss takes the lowest invalid way or else the shared round-robin pointer
        if (!hit) begin
            way = m_ptr;
            for (int w = 3; w >= 0; w--) begin
                if (!m_valid[s_idx][w]) begin
                    way = w;
                end
            end
            if (m_valid[s_idx][way]) begin
                if (m_dirty[s_idx][way]) begin
                    exp_addr[0] = {m_tag[s_idx][way], addr[7:4], 4'h0};
                    exp_wr[0]   = 1'b1;
                    exp_data[0] = block_of(exp_addr[0]);
                    n_exp       = 1;
                end
                m_ptr = (m_ptr + 1) % 4;
            end
            exp_addr[n_exp] = {addr[31:4], 4'h0};
            exp_wr[n_exp]   = 1'b0;
            n_exp++;
            m_tag[s_idx][way]   = addr[31:8];
            m_valid[s_idx][way] = 1'b1;
            m_dirty[s_idx][way] = 1'b0;
        end
        if (wr) begin
            m_dirty[s_idx][way] = 1'b1;
        end

        req_addr  = addr;
        req_write = wr;
        req_wdata = wdata;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        edges     = 0;
        if (wr) begin
            while (!req_ready) begin
                @(posedge clk);
                #1;
                edges++;
            end
        end else begin
            while (!rsp_valid) begin
                @(posedge clk);
                #1;
                edges++;
            end
            rsp_ready = pick_ready(rnd);
            while (!rsp_ready) begin
                @(posedge clk);
                #1;
                rsp_ready = pick_ready(rnd);
            end
            got = rsp_data;
            @(posedge clk);
            #1;
            check_value($sformatf("rsp_data_o at %h", addr), got, sb_mem[idx]);
        end
        if (hit) begin
            check_true(edges == 1, $sformatf("Hit at %h took %0d edges after acceptance",
                                             addr, edges));
        end

        check_true(q_addr.size() == n_exp,
                   $sformatf("Access at %h made %0d bus transfers, expected %0d",
                             addr, q_addr.size(), n_exp));
        for (int i = 0; i < n_exp && i < q_addr.size(); i++) begin
            check_value("bus_addr_o", q_addr[i], exp_addr[i]);
            check_value("bus_write_o", q_write[i], exp_wr[i]);
            if (exp_wr[i]) begin
                check_value("bus_wdata_o", q_data[i], exp_data[i]);
            end
        end
        q_addr.delete();
        q_write.delete();
        q_data.delete();
        if (wr) begin
            sb_mem[idx] = wdata;
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before all accesses finished, %0d errors", errors);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        logic [31:0] addr;
        void'($urandom(SEED));
        errors    = 0;
        m_ptr     = 0;
        req_addr  = '0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            sb_mem[i]          = mem_pattern(i);
            u_mem.mem_words[i] = sb_mem[i];
        end
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 4; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end

        @(posedge rstn);
        @(posedge clk);
        #1;
        check_value("rsp_valid_o", rsp_valid, 1'b0);
        check_value("bus_valid_o", bus_valid, 1'b0);
        check_value("bus_write_o", bus_write, 1'b0);
        check_value("bus_rready_o", bus_rready, 1'b0);
        check_value("req_ready_o", req_ready, 1'b1);

        // Read miss followed by a hit in the same block
        run_access(1'b0, 32'h0000_0110, '0, 1'b0);
        run_access(1'b0, 32'h0000_011c, '0, 1'b0);

        // Write hit and write miss with a read back of each
        run_access(1'b1, 32'h0000_0114, 32'h1234_5678, 1'b0);
        run_access(1'b0, 32'h0000_0114, '0, 1'b0);
        run_access(1'b1, 32'h0000_0218, 32'h8765_4321, 1'b0);
        run_access(1'b0, 32'h0000_0218, '0, 1'b0);

        // Five tags into set 5 so the fifth evicts a dirty way
        for (int t = 8; t < 13; t++) begin
            run_access(1'b1, (t << 8) | 32'h54, 32'ha000_0000 + t, 1'b0);
        end
        run_access(1'b0, 32'h0000_0854, '0, 1'b0);

        for (int n = 0; n < N_RAND; n++) begin
            addr = ($urandom_range(0, 7) << 8) | ($urandom_range(0, 15) << 4)
                 | ($urandom_range(0, 3) << 2);
            run_access($urandom_range(0, 1), addr, $urandom, 1'b1);
        end

        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
